/* tb.f */
+incdir+.
decodePkg.sv
immGen.sv
ctrlDecode.sv
loadUseDetect.sv
decodeStage.sv
tbDecode.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tbDecode -o simDecode
./obj_dir/simDecode > sim.log
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

/* tbModel.svh */
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

localparam aluOpE intTable [8] = '{aluAdd, aluSll, aluSlt, aluSltu,
                                   aluXor, aluSrl, aluOr, aluAnd};
// funct3 2 and 3 are not branches
localparam aluOpE brTable [8] = '{aluBeq, aluBne, aluAdd, aluAdd,
                                  aluBlt, aluBge, aluBltu, aluBgeu};

function automatic logic [31:0] signExtend(input logic [31:0] v, input int w);
    logic signed [31:0] s;
    s = v << (32 - w);
    return s >>> (32 - w);
endfunction

function automatic ctrlT baseCtrl(input logic a, input selBE b, input logic toReg,
                                  input logic r1, input logic r2, input immFmtE f);
    ctrlT c;
    c = '0;
    c.aluOp = aluAdd;
    c.selA = a;
    c.selB = b;
    c.aluToReg = toReg;
    c.readsRs1 = r1;
    c.readsRs2 = r2;
    c.immFmt = f;
    return c;
endfunction

function automatic ctrlT modelCtrl(input logic [31:0] ins);
    ctrlT c;
    logic [2:0] f3;
    logic [6:0] f7;
    logic ok;
    f3 = ins[14:12];
    f7 = ins[31:25];
    c = '0;
    ok = 1'b1;
    case (ins[6:0])
        7'b0110011: begin
            c = baseCtrl(1'b0, selRs2, 1'b1, 1'b1, 1'b1, immNone);
            c.aluOp = (f7 == 7'h20 && f3 == 3'd0) ? aluSub :
                      (f7 == 7'h20) ? aluSra : intTable[f3];
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end
        7'b0010011: begin
            c = baseCtrl(1'b0, selImm, 1'b1, 1'b1, 1'b0, immI);
            c.aluOp = intTable[f3];
            if (f3 == 3'd1 || f3 == 3'd5) begin
                c.immFmt = immShift;
                c.aluOp = (f7 == 7'h20) ? aluSra : c.aluOp;
                ok = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
            end
        end
        7'b0000011: begin
            c = baseCtrl(1'b0, selImm, 1'b0, 1'b1, 1'b0, immI);
            c.memOp = f3[2] ? memReadZext : memReadSext;
            c.memSize = (f3[1:0] == 2'd0) ? sizeByte : (f3[1:0] == 2'd1) ? sizeHalf : sizeWord;
            ok = (f3 != 3'd3) && (f3 < 3'd6);
        end
        7'b0100011: begin
            c = baseCtrl(1'b0, selImm, 1'b0, 1'b1, 1'b1, immS);
            c.memOp = memWrite;
            c.memSize = (f3[1:0] == 2'd0) ? sizeByte : (f3[1:0] == 2'd1) ? sizeHalf : sizeWord;
            ok = (f3 < 3'd3);
        end
        7'b1100011: begin
            c = baseCtrl(1'b0, selRs2, 1'b0, 1'b1, 1'b1, immB);
            c.branch = 1'b1;
            c.aluOp = brTable[f3];
            ok = (f3 != 3'd2) && (f3 != 3'd3);
        end
        7'b1101111: begin
            c = baseCtrl(1'b1, selFour, 1'b1, 1'b0, 1'b0, immJ);
            c.jal = 1'b1;
        end
        7'b1100111: begin
            c = baseCtrl(1'b1, selFour, 1'b1, 1'b1, 1'b0, immI);
            c.jalr = 1'b1;
            ok = (f3 == 3'd0);
        end
        7'b0110111: c = baseCtrl(1'b0, selImm, 1'b1, 1'b0, 1'b0, immU);
        7'b0010111: c = baseCtrl(1'b1, selImm, 1'b1, 1'b0, 1'b0, immU);
        default: ok = 1'b0;
    endcase
    return ok ? c : ctrlT'('0);
endfunction

function automatic logic [31:0] modelImm(input logic [31:0] ins, input immFmtE fmt);
    case (fmt)
        immI: return signExtend({20'b0, ins[31:20]}, 12);
        immShift: return {27'b0, ins[24:20]};
        immS: return signExtend({20'b0, ins[31:25], ins[11:7]}, 12);
        immB: return signExtend({19'b0, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
        immU: return {ins[31:12], 12'b0};
        immJ: return signExtend({11'b0, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
        default: return '0;
    endcase
endfunction

function automatic decodeOutT modelOut(input logic [31:0] ins, input logic [31:0] pc);
    decodeOutT e;
    ctrlT c;
    logic writes;
    c = modelCtrl(ins);
    e = '0;
    // Bubble stays all zero
    if (c != '0) begin
        writes = c.aluToReg || c.memOp == memReadSext || c.memOp == memReadZext;
        e.rs1 = c.readsRs1 ? ins[19:15] : 5'd0;
        e.rs2 = c.readsRs2 ? ins[24:20] : 5'd0;
        e.rd = writes ? ins[11:7] : 5'd0;
        e.imm = modelImm(ins, c.immFmt);
        e.ctrl = c;
        e.pc = pc;
    end
    return e;
endfunction

function automatic logic modelCollision(input decodeOutT e, input logic loadValid,
                                        input logic [4:0] loadRd);
    return loadValid && ((e.ctrl.readsRs1 && e.rs1 == loadRd) ||
                         (e.ctrl.readsRs2 && e.rs2 == loadRd));
endfunction

`endif

/* tbDecode.sv */
`timescale 1ns/100ps

module tbDecode
    import decodePkg::*;
();

    localparam int numTests = 3000;
    localparam int resetCycles = 5;

    logic        clk = 1'b0;
    logic        arstN;
    logic [31:0] instr;
    logic [31:0] pcIn;
    logic        hold;
    decodeOutT   out;
    logic        collision;

    logic [31:0] lfsr;
    decodeOutT   expOut;
    logic        expCollision;
    logic        lastLoadValid;
    logic [4:0]  lastLoadRd;
    int          outErrors;
    int          collisionErrors;

    `include "tbModel.svh"

    decodeStage dut0 (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .pcIn      (pcIn),
        .hold      (hold),
        .out       (out),
        .collision (collision)
    );

    always #2 clk = ~clk;

    // Right-shift Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Few registers so that loads and readers meet
    function automatic logic [4:0] pickReg(input logic [1:0] k);
        case (k)
            2'd0: return 5'd0;
            2'd1: return 5'd5;
            2'd2: return 5'd9;
            default: return 5'd31;
        endcase
    endfunction

    task automatic makeInstr(output logic [31:0] ins);
        logic [31:0] kind;
        logic [31:0] f7Kind;
        logic [6:0]  op;
        logic [6:0]  f7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  f3;
        logic [4:0]  rd;
        kind = randBits(4);
        case (kind[3:0])
            4'd2, 4'd3: op = 7'b0110011;
            4'd4, 4'd5: op = 7'b0010011;
            4'd6, 4'd7: op = 7'b0000011;
            4'd8, 4'd9: op = 7'b0100011;
            4'd10, 4'd11: op = 7'b1100011;
            4'd12: op = 7'b1101111;
            4'd13: op = 7'b1100111;
            4'd14: op = 7'b0110111;
            4'd15: op = 7'b0010111;
            default: op = 7'(randBits(7));
        endcase
        f7Kind = randBits(2);
        f7 = (f7Kind[1:0] == 2'd0) ? 7'(randBits(7)) : (f7Kind[0] ? 7'h20 : 7'h00);
        rs2 = 5'(randBits(5));
        rs1 = pickReg(2'(randBits(2)));
        f3 = 3'(randBits(3));
        rd = pickReg(2'(randBits(2)));
        ins = {f7, rs2, rs1, f3, rd, op};
    endtask

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            outErrors++;
        end
    endtask

    task automatic checkOut(input decodeOutT got, input decodeOutT exp);
        compareField("out.rs1", 32'(got.rs1), 32'(exp.rs1));
        compareField("out.rs2", 32'(got.rs2), 32'(exp.rs2));
        compareField("out.rd", 32'(got.rd), 32'(exp.rd));
        compareField("out.imm", got.imm, exp.imm);
        compareField("out.ctrl", 32'(got.ctrl), 32'(exp.ctrl));
        compareField("out.pc", got.pc, exp.pc);
    endtask

    task automatic checkCollision(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR t=%0t collision got %b expected %b", $time, got, exp);
            collisionErrors++;
        end
    endtask

    initial begin
        logic [31:0] ins;
        logic [31:0] holdDraw;
        arstN = 1'b0;
        // LW x5 with a live pc while reset is held
        instr = 32'h0000_2283;
        pcIn = 32'h0000_1000;
        hold = 1'b0;
        lfsr = 32'hcbe9;
        expOut = '0;
        expCollision = 1'b0;
        lastLoadValid = 1'b0;
        lastLoadRd = '0;
        outErrors = 0;
        collisionErrors = 0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkOut(out, expOut);
        checkCollision(collision, expCollision);
        for (int i = 0; i < numTests; i++) begin
            makeInstr(ins);
            instr = ins;
            pcIn = randBits(32);
            holdDraw = randBits(2);
            hold = (holdDraw[1:0] == 2'd0);
            if (!hold) begin
                expOut = modelOut(instr, pcIn);
                expCollision = modelCollision(expOut, lastLoadValid, lastLoadRd);
                lastLoadValid = (expOut.ctrl.memOp == memReadSext ||
                                 expOut.ctrl.memOp == memReadZext) && expOut.rd != 5'd0;
                lastLoadRd = expOut.rd;
            end
            @(negedge clk);
            checkOut(out, expOut);
            checkCollision(collision, expCollision);
        end
        $display("Errors: out %0d, collision %0d", outErrors, collisionErrors);
        if (outErrors + collisionErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(numTests * 4 * 2 + resetCycles * 4);
        $display("Watchdog expired, the run timed out before all tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* decodeStage.sv */
`timescale 1ns/100ps

module decodeStage
    import decodePkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] instr,
    input  logic [31:0] pcIn,
    input  logic        hold,
    output decodeOutT   out,
    output logic        collision
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    ctrlT                ctrl;
    logic [xlen-1:0]     imm;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
    logic                isLoad;
    logic                writesRd;
    logic                accept;
    logic                collisionNext;
    decodeOutT           outNext;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign accept = !hold;

    ctrlDecode ctrlDecode0 (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctrl   (ctrl)
    );

    immGen immGen0 (
        .instr (instr),
        .fmt   (ctrl.immFmt),
        .imm   (imm)
    );

    assign isLoad = (ctrl.memOp == memReadSext) || (ctrl.memOp == memReadZext);
    assign writesRd = ctrl.aluToReg || isLoad;

    // Unused register fields reported as zero
    assign rs1 = ctrl.readsRs1 ? instr[19:15] : '0;
    assign rs2 = ctrl.readsRs2 ? instr[24:20] : '0;
    assign rd = writesRd ? instr[11:7] : '0;

    loadUseDetect loadUseDetect0 (
        .clk           (clk),
        .arstN         (arstN),
        .accept        (accept),
        .rs1           (rs1),
        .rs2           (rs2),
        .readsRs1      (ctrl.readsRs1),
        .readsRs2      (ctrl.readsRs2),
        .isLoad        (isLoad),
        .rd            (rd),
        .collisionNext (collisionNext)
    );

    always_comb begin
        outNext.rs1 = rs1;
        outNext.rs2 = rs2;
        outNext.rd = rd;
        outNext.imm = imm;
        outNext.ctrl = ctrl;
        // A bubble carries no pc either
        outNext.pc = (ctrl == '0) ? '0 : pcIn;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            out <= '0;
            collision <= 1'b0;
        end else if (accept) begin
            out <= outNext;
            collision <= collisionNext;
        end
    end

    // Control flow kinds are exclusive
    assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({out.ctrl.branch, out.ctrl.jal, out.ctrl.jalr}));

    // Size only means something for memory access
    assert property (@(posedge clk) disable iff (!arstN)
        (out.ctrl.memSize != sizeByte) |-> (out.ctrl.memOp != memDisable));

endmodule

/* loadUseDetect.sv */
`timescale 1ns/100ps

module loadUseDetect
    import decodePkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                accept,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  logic                readsRs1,
    input  logic                readsRs2,
    input  logic                isLoad,
    input  logic [regAddrW-1:0] rd,
    output logic                collisionNext
);

    logic                loadValid;
    logic [regAddrW-1:0] loadRd;

    // Kept only for a load into a real register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            loadValid <= 1'b0;
            loadRd <= '0;
        end else if (accept) begin
            loadValid <= isLoad && (rd != '0);
            loadRd <= rd;
        end
    end

    assign collisionNext = loadValid &&
                           ((readsRs1 && rs1 == loadRd) || (readsRs2 && rs2 == loadRd));

    // Unread indices arrive as zero from the top
    assert property (@(posedge clk) disable iff (!arstN)
        (readsRs1 || rs1 == '0) && (readsRs2 || rs2 == '0));

endmodule

/* ctrlDecode.sv */
`timescale 1ns/100ps

module ctrlDecode
    import decodePkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output ctrlT       ctrl
);

    ctrlT c;
    logic legal;
    logic alt;

    // Integer op from funct3; alt selects SUB or SRA
    function automatic aluOpE aluArith(input logic [2:0] f3, input logic altOp);
        aluOpE op;
        case (f3)
            3'b000:  op = altOp ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = altOp ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    function automatic aluOpE aluBranch(input logic [2:0] f3);
        aluOpE op;
        case (f3)
            3'b000:  op = aluBeq;
            3'b001:  op = aluBne;
            3'b100:  op = aluBlt;
            3'b101:  op = aluBge;
            3'b110:  op = aluBltu;
            default: op = aluBgeu;
        endcase
        return op;
    endfunction

    // Bit 30 of the instruction
    assign alt = funct7[5];

    always_comb begin
        c = '0;
        legal = 1'b0;
        case (opcode)
            opR: begin
                c.selB = selRs2;
                c.aluToReg = 1'b1;
                c.readsRs1 = 1'b1;
                c.readsRs2 = 1'b1;
                c.aluOp = aluArith(funct3, alt);
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opI: begin
                c.selB = selImm;
                c.aluToReg = 1'b1;
                c.readsRs1 = 1'b1;
                // ADDI has no subtract form
                c.aluOp = aluArith(funct3, alt && funct3 == 3'b101);
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    c.immFmt = immShift;
                    legal = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && funct3 == 3'b101);
                end else begin
                    c.immFmt = immI;
                    legal = 1'b1;
                end
            end
            opLoad: begin
                c.aluOp = aluAdd;
                c.selB = selImm;
                c.readsRs1 = 1'b1;
                c.immFmt = immI;
                c.memOp = funct3[2] ? memReadZext : memReadSext;
                c.memSize = memSizeE'(funct3[1:0]);
                legal = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end
            opStore: begin
                c.aluOp = aluAdd;
                c.selB = selImm;
                c.readsRs1 = 1'b1;
                c.readsRs2 = 1'b1;
                c.immFmt = immS;
                c.memOp = memWrite;
                c.memSize = memSizeE'(funct3[1:0]);
                legal = funct3 inside {3'b000, 3'b001, 3'b010};
            end
            opBranch: begin
                c.aluOp = aluBranch(funct3);
                c.selB = selRs2;
                c.branch = 1'b1;
                c.readsRs1 = 1'b1;
                c.readsRs2 = 1'b1;
                c.immFmt = immB;
                legal = !(funct3 inside {3'b010, 3'b011});
            end
            opJal: begin
                // Link value is pc + 4
                c.aluOp = aluAdd;
                c.selA = 1'b1;
                c.selB = selFour;
                c.aluToReg = 1'b1;
                c.jal = 1'b1;
                c.immFmt = immJ;
                legal = 1'b1;
            end
            opJalr: begin
                c.aluOp = aluAdd;
                c.selA = 1'b1;
                c.selB = selFour;
                c.aluToReg = 1'b1;
                c.jalr = 1'b1;
                c.readsRs1 = 1'b1;
                c.immFmt = immI;
                legal = (funct3 == 3'b000);
            end
            opLui: begin
                // x0 + imm
                c.aluOp = aluAdd;
                c.selB = selImm;
                c.aluToReg = 1'b1;
                c.immFmt = immU;
                legal = 1'b1;
            end
            opAuipc: begin
                c.aluOp = aluAdd;
                c.selA = 1'b1;
                c.selB = selImm;
                c.aluToReg = 1'b1;
                c.immFmt = immU;
                legal = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        ctrl = legal ? c : '0;
    end

endmodule

/* immGen.sv */
`timescale 1ns/100ps

module immGen
    import decodePkg::*;
(
    input  logic [31:0]     instr,
    input  immFmtE          fmt,
    output logic [xlen-1:0] imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            immI: begin
                imm = {{(xlen-12){sign}}, instr[31:20]};
            end
            immShift: begin
                // Shift amount only, never sign-extended
                imm = {{(xlen-5){1'b0}}, instr[24:20]};
            end
            immS: begin
                imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            end
            immB: begin
                // Offset in halfwords, bit 0 always zero
                imm = {{(xlen-13){sign}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            immU: begin
                imm = {instr[31:12], 12'b0};
            end
            immJ: begin
                imm = {{(xlen-21){sign}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* decodePkg.sv */
package decodePkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Major opcodes kept by the decoder
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opI      = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opR      = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeE;

    // ALU and compare operations
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluAnd  = 4'b0010,
        aluOr   = 4'b0011,
        aluXor  = 4'b0100,
        aluSll  = 4'b0101,
        aluSrl  = 4'b0110,
        aluSra  = 4'b0111,
        aluSlt  = 4'b1000,
        aluSltu = 4'b1001,
        aluBeq  = 4'b1010,
        aluBne  = 4'b1011,
        aluBlt  = 4'b1100,
        aluBge  = 4'b1101,
        aluBltu = 4'b1110,
        aluBgeu = 4'b1111
    } aluOpE;

    typedef enum logic [1:0] {
        memDisable  = 2'b00,
        memReadSext = 2'b01,
        memReadZext = 2'b10,
        memWrite    = 2'b11
    } memOpE;

    // Encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } memSizeE;

    // Operand B source
    typedef enum logic [1:0] {
        selRs2  = 2'b00,
        selImm  = 2'b01,
        selFour = 2'b10
    } selBE;

    typedef enum logic [2:0] {
        immNone  = 3'd0,
        immI     = 3'd1,
        immShift = 3'd2,
        immS     = 3'd3,
        immB     = 3'd4,
        immU     = 3'd5,
        immJ     = 3'd6
    } immFmtE;

    typedef struct packed {
        aluOpE   aluOp;
        logic    selA;       // 0 rs1, 1 pc
        selBE    selB;
        logic    aluToReg;
        memOpE   memOp;
        memSizeE memSize;
        logic    branch;
        logic    jal;
        logic    jalr;
        logic    readsRs1;
        logic    readsRs2;
        immFmtE  immFmt;
    } ctrlT;

    typedef struct packed {
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     imm;
        ctrlT                ctrl;
        logic [xlen-1:0]     pc;
    } decodeOutT;

endpackage
